// ==== hw/ahb_out_pkg.sv ====
// Widths, port count, HTRANS encodings and arbiter state type for the AHB output stage

package ahb_out_pkg;

  // ----------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------
  localparam int N_PORTS  = 4;                // Master-side input ports
  localparam int PORT_W   = $clog2(N_PORTS);  // Port index width
  localparam int ADDR_W   = 32;               // HADDR width
  localparam int DATA_W   = 32;               // HWDATA width

  localparam int SIZE_W   = 3;                // HSIZE width
  localparam int BURST_W  = 3;                // HBURST width
  localparam int PROT_W   = 4;                // HPROT width
  localparam int MASTER_W = 4;                // HMASTER width

  // ----------------------------------------------------------
  // Types
  // ----------------------------------------------------------
  typedef logic [PORT_W-1:0] port_idx_t;      // Input port number
  typedef logic [1:0]        trans_t;         // HTRANS field

  // HTRANS encodings
  localparam trans_t HTRANS_IDLE   = 2'b00;   // No transfer
  localparam trans_t HTRANS_BUSY   = 2'b01;   // Burst pause
  localparam trans_t HTRANS_NONSEQ = 2'b10;   // First beat or single
  localparam trans_t HTRANS_SEQ    = 2'b11;   // Following beat

  // Arbiter state
  // A lock holds the grant across beats and across cycles
  // where the master addresses some other slave
  typedef enum logic [1:0] {
    ARB_IDLE  = 2'b00,                        // Nothing granted
    ARB_GRANT = 2'b01,                        // Port granted, unlocked
    ARB_LOCK  = 2'b10                         // Locked sequence owns grant
  } arb_state_e;

endpackage

// ==== hw/ahb_addr_if.sv ====
// Interface carrying the selected address phase inside the output stage

`timescale 1ns/100ps

interface ahb_addr_if import ahb_out_pkg::*; ();

  logic                sel;       // HSEL of granted port
  trans_t              trans;     // Transfer type
  logic                write;     // Direction
  logic [SIZE_W-1:0]   size;      // Transfer size
  logic [BURST_W-1:0]  burst;     // Burst type
  logic [PROT_W-1:0]   prot;      // Protection
  logic [MASTER_W-1:0] master;    // Master ID
  logic                mastlock;  // Locked transfer
  logic [ADDR_W-1:0]   addr;      // Address

  // Address mux drives everything
  modport mux (output sel, trans, write, size, burst, prot, master, mastlock, addr);

  // Ready and lock tracking only watch these
  modport mon (input sel, trans, mastlock);

  // Top-level view onto the slave outputs
  modport out (input sel, trans, write, size, burst, prot, master, mastlock, addr);

endinterface

// ==== hw/ahb_out_arbiter.sv ====
// Round-robin arbiter with lock hold for the shared slave port

`timescale 1ns/100ps

module ahb_out_arbiter import ahb_out_pkg::*; (
  input  logic               HCLK,          // AHB clock
  input  logic               HRESETn,       // Sync reset, active low
  input  logic [N_PORTS-1:0] i_req,         // Per-port request
  input  logic               i_hreadymux,   // Address phase accepted
  input  logic               i_hlock_arb,   // Masked HMASTLOCK
  output port_idx_t          o_grant_port,  // Granted port
  output logic               o_no_port      // Nothing granted
);

  // ----------------------------------------------------------
  // State
  // ----------------------------------------------------------
  arb_state_e arb_state;                    // Current state
  arb_state_e next_state;                   // Next state
  port_idx_t  grant_port;                   // Grant, also last-granted pointer
  port_idx_t  next_port;                    // Next grant
  logic       no_port;                      // Nothing granted
  logic       next_no_port;                 // Next no_port
  port_idx_t  scan_idx;                     // Candidate in round-robin scan
  logic       found;                        // Scan hit a requester

  // ----------------------------------------------------------
  // Next grant
  // ----------------------------------------------------------
  always_comb
  begin
    found        = 1'b0;
    scan_idx     = grant_port;
    next_port    = grant_port;              // Default keep
    next_no_port = no_port;
    next_state   = arb_state;

    if ((arb_state == ARB_LOCK) || i_hlock_arb)
    begin
      // Locked owner keeps the port
      next_state = i_hlock_arb ? ARB_LOCK : ARB_GRANT;
    end
    else
    begin
      // Upward search from port after last grant, current port last
      for (int off = 1; off <= N_PORTS; off++)
      begin
        scan_idx = grant_port + port_idx_t'(off);   // Wraps at N_PORTS
        if (!found && i_req[scan_idx])
        begin
          found     = 1'b1;
          next_port = scan_idx;
        end
      end

      if (found)
      begin
        next_state   = ARB_GRANT;
        next_no_port = 1'b0;
      end
      else
      begin
        next_state   = ARB_IDLE;            // Pointer stays put
        next_no_port = 1'b1;
      end
    end
  end

  // ----------------------------------------------------------
  // Registers, advance only on accepted phases
  // ----------------------------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      arb_state  <= ARB_IDLE;
      grant_port <= port_idx_t'(N_PORTS - 1);   // Port 0 wins first
      no_port    <= 1'b1;
    end
    else if (i_hreadymux)
    begin
      arb_state  <= next_state;
      grant_port <= next_port;
      no_port    <= next_no_port;
    end
  end

  assign o_grant_port = grant_port;
  assign o_no_port    = no_port;

endmodule

// ==== hw/ahb_addr_mux.sv ====
// Address and control multiplexer for the granted input port

`timescale 1ns/100ps

module ahb_addr_mux import ahb_out_pkg::*; (
  input  port_idx_t           i_grant_port,         // Granted port
  input  logic                i_no_port,            // Nothing granted
  input  logic [N_PORTS-1:0]  i_sel,                // Per-port HSEL
  input  logic [ADDR_W-1:0]   i_addr     [N_PORTS], // Per-port HADDR
  input  trans_t              i_trans    [N_PORTS], // Per-port HTRANS
  input  logic [N_PORTS-1:0]  i_write,              // Per-port HWRITE
  input  logic [SIZE_W-1:0]   i_size     [N_PORTS], // Per-port HSIZE
  input  logic [BURST_W-1:0]  i_burst    [N_PORTS], // Per-port HBURST
  input  logic [PROT_W-1:0]   i_prot     [N_PORTS], // Per-port HPROT
  input  logic [MASTER_W-1:0] i_master   [N_PORTS], // Per-port HMASTER
  input  logic [N_PORTS-1:0]  i_mastlock,           // Per-port HMASTLOCK
  ahb_addr_if.mux             addr_o                // Selected address phase
);

  // ----------------------------------------------------------
  // Port select
  // ----------------------------------------------------------
  always_comb
  begin
    if (i_no_port)
    begin
      // Idle bus, everything low
      addr_o.sel      = 1'b0;
      addr_o.trans    = HTRANS_IDLE;
      addr_o.write    = 1'b0;
      addr_o.size     = '0;
      addr_o.burst    = '0;
      addr_o.prot     = '0;
      addr_o.master   = '0;
      addr_o.mastlock = 1'b0;
      addr_o.addr     = '0;
    end
    else
    begin
      // Index covers every port, no fallback case
      addr_o.sel      = i_sel[i_grant_port];
      addr_o.trans    = i_trans[i_grant_port];
      addr_o.write    = i_write[i_grant_port];
      addr_o.size     = i_size[i_grant_port];
      addr_o.burst    = i_burst[i_grant_port];     // Passed through as is
      addr_o.prot     = i_prot[i_grant_port];
      addr_o.master   = i_master[i_grant_port];
      addr_o.mastlock = i_mastlock[i_grant_port];
      addr_o.addr     = i_addr[i_grant_port];
    end
  end

endmodule

// ==== hw/ahb_data_mux.sv ====
// Data-phase port register and write data multiplexer

`timescale 1ns/100ps

module ahb_data_mux import ahb_out_pkg::*; (
  input  logic              HCLK,                // AHB clock
  input  logic              HRESETn,             // Sync reset, active low
  input  port_idx_t         i_grant_port,        // Address-phase port
  input  logic              i_hreadymux,         // Address phase accepted
  input  logic [DATA_W-1:0] i_wdata   [N_PORTS], // Per-port HWDATA
  output logic [DATA_W-1:0] o_hwdata             // Slave HWDATA
);

  port_idx_t data_port;                          // Owner of current data phase

  // ----------------------------------------------------------
  // Data-phase owner
  // ----------------------------------------------------------
  // Follows the address phase by one accepted transfer
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      data_port <= '0;
    end
    else if (i_hreadymux)
    begin
      data_port <= i_grant_port;                 // Hold under wait states
    end
  end

  // Write data select
  assign o_hwdata = i_wdata[data_port];

endmodule

// ==== hw/ahb_ready_lock.sv ====
// Multiplexed ready generation and lock tracking for arbitration

`timescale 1ns/100ps

module ahb_ready_lock import ahb_out_pkg::*; (
  input  logic    HCLK,          // AHB clock
  input  logic    HRESETn,       // Sync reset, active low
  input  logic    i_hreadyout,   // Slave HREADYOUT
  ahb_addr_if.mon addr_i,        // Selected address phase
  output logic    o_hreadymux,   // Multiplexed HREADY
  output logic    o_hlock_arb    // Lock seen by the arbiter
);

  logic slave_sel;               // Slave owns current data phase
  logic hsel_lock;               // Locked sequence started here
  logic next_hsel_lock;          // Next hsel_lock
  logic lock_start;              // Locked transfer to this slave

  // ----------------------------------------------------------
  // Ready mux
  // ----------------------------------------------------------
  // Only a selected slave can stretch the data phase
  assign o_hreadymux = slave_sel ? i_hreadyout : 1'b1;

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      slave_sel <= 1'b0;
    else if (o_hreadymux)
      slave_sel <= addr_i.sel;
  end

  // ----------------------------------------------------------
  // Lock tracking
  // ----------------------------------------------------------
  // Master may address other slaves mid-sequence, HSEL drops but
  // the lock must survive until HMASTLOCK goes away
  assign lock_start = addr_i.sel & addr_i.mastlock &
                      ((addr_i.trans == HTRANS_NONSEQ) || (addr_i.trans == HTRANS_SEQ));

  always_comb
  begin
    if (lock_start)
      next_hsel_lock = 1'b1;
    else if (!addr_i.mastlock)
      next_hsel_lock = 1'b0;           // Sequence over
    else
      next_hsel_lock = hsel_lock;
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      hsel_lock <= 1'b0;
    else if (o_hreadymux)
      hsel_lock <= next_hsel_lock;
  end

  // HMASTLOCK counts only if selected or already locked through us
  assign o_hlock_arb = addr_i.mastlock & (addr_i.sel | hsel_lock);

endmodule

// ==== hw/ahb_out_stage.sv ====
// AHB bus matrix output stage top level: arbiter, address, data and ready paths

`timescale 1ns/100ps

module ahb_out_stage import ahb_out_pkg::*; (
  input  logic                HCLK,                 // AHB clock
  input  logic                HRESETn,              // Sync reset, active low

  // Master-side input ports
  input  logic [N_PORTS-1:0]  i_sel,                // HSEL
  input  logic [N_PORTS-1:0]  i_held_tran,          // Pending transfer
  input  logic [ADDR_W-1:0]   i_addr     [N_PORTS], // HADDR
  input  trans_t              i_trans    [N_PORTS], // HTRANS
  input  logic [N_PORTS-1:0]  i_write,              // HWRITE
  input  logic [SIZE_W-1:0]   i_size     [N_PORTS], // HSIZE
  input  logic [BURST_W-1:0]  i_burst    [N_PORTS], // HBURST
  input  logic [PROT_W-1:0]   i_prot     [N_PORTS], // HPROT
  input  logic [MASTER_W-1:0] i_master   [N_PORTS], // HMASTER
  input  logic [N_PORTS-1:0]  i_mastlock,           // HMASTLOCK
  input  logic [DATA_W-1:0]   i_wdata    [N_PORTS], // HWDATA

  // Shared slave
  input  logic                i_hreadyoutm,         // Slave HREADYOUT

  output logic [N_PORTS-1:0]  o_active,             // One-hot granted port
  output logic                o_hselm,              // Slave select
  output logic [ADDR_W-1:0]   o_haddrm,             // Address
  output trans_t              o_htransm,            // Transfer type
  output logic                o_hwritem,            // Direction
  output logic [SIZE_W-1:0]   o_hsizem,             // Size
  output logic [BURST_W-1:0]  o_hburstm,            // Burst type
  output logic [PROT_W-1:0]   o_hprotm,             // Protection
  output logic [MASTER_W-1:0] o_hmasterm,           // Master ID
  output logic                o_hmastlockm,         // Locked transfer
  output logic                o_hreadymuxm,         // Multiplexed ready
  output logic [DATA_W-1:0]   o_hwdatam             // Write data
);

  // ----------------------------------------------------------
  // Internal signals
  // ----------------------------------------------------------
  logic [N_PORTS-1:0] req;             // Per-port request
  port_idx_t          grant_port;      // Address-phase port
  logic               no_port;         // Nothing granted
  logic               hreadymux;       // Accept strobe for all registers
  logic               hlock_arb;       // Lock into arbiter

  ahb_addr_if addr_bus ();             // Selected address phase

  // A port asks only when it has a transfer aimed at this slave
  assign req = i_held_tran & i_sel;

  // ----------------------------------------------------------
  // Arbitration
  // ----------------------------------------------------------
  ahb_out_arbiter u_arbiter (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_req        (req),
    .i_hreadymux  (hreadymux),
    .i_hlock_arb  (hlock_arb),
    .o_grant_port (grant_port),
    .o_no_port    (no_port)
  );

  // Active flags
  always_comb
  begin
    o_active = '0;
    if (!no_port)
      o_active[grant_port] = 1'b1;
  end

  // ----------------------------------------------------------
  // Datapath
  // ----------------------------------------------------------
  ahb_addr_mux u_addr_mux (
    .i_grant_port (grant_port),
    .i_no_port    (no_port),
    .i_sel        (i_sel),
    .i_addr       (i_addr),
    .i_trans      (i_trans),
    .i_write      (i_write),
    .i_size       (i_size),
    .i_burst      (i_burst),
    .i_prot       (i_prot),
    .i_master     (i_master),
    .i_mastlock   (i_mastlock),
    .addr_o       (addr_bus.mux)
  );

  ahb_data_mux u_data_mux (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_grant_port (grant_port),
    .i_hreadymux  (hreadymux),
    .i_wdata      (i_wdata),
    .o_hwdata     (o_hwdatam)
  );

  ahb_ready_lock u_ready_lock (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_hreadyout  (i_hreadyoutm),
    .addr_i       (addr_bus.mon),
    .o_hreadymux  (hreadymux),
    .o_hlock_arb  (hlock_arb)
  );

  // ----------------------------------------------------------
  // Slave outputs
  // ----------------------------------------------------------
  assign o_hselm      = addr_bus.sel;
  assign o_haddrm     = addr_bus.addr;
  assign o_htransm    = addr_bus.trans;
  assign o_hwritem    = addr_bus.write;
  assign o_hsizem     = addr_bus.size;
  assign o_hburstm    = addr_bus.burst;
  assign o_hprotm     = addr_bus.prot;
  assign o_hmasterm   = addr_bus.master;
  assign o_hmastlockm = addr_bus.mastlock;
  assign o_hreadymuxm = hreadymux;      // Same ready fed back internally

endmodule

// ==== verification/tb_ahb_out_stage.sv ====
// Table-driven testbench with clock, reset, reference model and checks for the AHB output stage

`timescale 1ns/100ps

module tb_ahb_out_stage import ahb_out_pkg::*; ();

  // ----------------------------------------------------------
  // DUT signals
  // ----------------------------------------------------------
  logic                HCLK;
  logic                HRESETn;
  logic [N_PORTS-1:0]  sel, held_tran, write, mastlock;
  logic [ADDR_W-1:0]   addr   [N_PORTS];
  trans_t              trans  [N_PORTS];
  logic [SIZE_W-1:0]   size   [N_PORTS];
  logic [BURST_W-1:0]  burst  [N_PORTS];
  logic [PROT_W-1:0]   prot   [N_PORTS];
  logic [MASTER_W-1:0] master [N_PORTS];
  logic [DATA_W-1:0]   wdata  [N_PORTS];
  logic                hreadyoutm;
  logic [N_PORTS-1:0]  o_active;
  logic                o_hselm, o_hwritem, o_hmastlockm, o_hreadymuxm;
  logic [ADDR_W-1:0]   o_haddrm;
  trans_t              o_htransm;
  logic [SIZE_W-1:0]   o_hsizem;
  logic [BURST_W-1:0]  o_hburstm;
  logic [PROT_W-1:0]   o_hprotm;
  logic [MASTER_W-1:0] o_hmasterm;
  logic [DATA_W-1:0]   o_hwdatam;

  // Stimulus table row
  typedef struct packed {
    logic [3:0] test;                      // Test number
    logic [3:0] sel;                       // Per-port HSEL
    logic [3:0] held;                      // Per-port pending transfer
    logic [3:0] lock;                      // Per-port HMASTLOCK
    logic       ready;                     // Slave HREADYOUT
    logic       write;                     // HWRITE of pending ports
    trans_t     trans;                     // HTRANS of pending ports
  } row_t;

  row_t tbl [64];
  int   n_rows = 0;
  int   n_checks = 0;
  int   n_errors = 0;
  int   test_errors = 0;
  int   n_tests = 0;

  // Reference model state
  port_idx_t m_grant;                      // Grant and round-robin pointer
  logic      m_no_port, m_locked, m_slave_sel, m_hsel_lock;
  port_idx_t m_data_port;                  // Data-phase owner

  ahb_out_stage i_ahb_out_stage (
    .HCLK (HCLK), .HRESETn (HRESETn),
    .i_sel (sel), .i_held_tran (held_tran), .i_addr (addr), .i_trans (trans),
    .i_write (write), .i_size (size), .i_burst (burst), .i_prot (prot),
    .i_master (master), .i_mastlock (mastlock), .i_wdata (wdata),
    .i_hreadyoutm (hreadyoutm),
    .o_active (o_active), .o_hselm (o_hselm), .o_haddrm (o_haddrm),
    .o_htransm (o_htransm), .o_hwritem (o_hwritem), .o_hsizem (o_hsizem),
    .o_hburstm (o_hburstm), .o_hprotm (o_hprotm), .o_hmasterm (o_hmasterm),
    .o_hmastlockm (o_hmastlockm), .o_hreadymuxm (o_hreadymuxm),
    .o_hwdatam (o_hwdatam)
  );

  always #5 HCLK = ~HCLK;                  // 10 ns period

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    n_checks++;
    if (actual !== expected)
    begin
      $display("Fail %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
      n_errors++;
      test_errors++;
    end
  endtask

  task automatic add_row(input int test, input logic [3:0] s, input logic [3:0] h,
                         input logic [3:0] l, input logic rdy, input logic wr,
                         input trans_t tr);
    tbl[n_rows].test  = test[3:0];
    tbl[n_rows].sel   = s;
    tbl[n_rows].held  = h;
    tbl[n_rows].lock  = l;
    tbl[n_rows].ready = rdy;
    tbl[n_rows].write = wr;
    tbl[n_rows].trans = tr;
    n_rows++;
  endtask

  // First requester after the pointer with wraparound
  task automatic round_robin(input logic [3:0] req, output logic found, output port_idx_t pick);
    int idx;
    found = 1'b0;
    pick  = m_grant;
    for (int k = 0; k < N_PORTS; k++)
    begin
      idx = (int'(m_grant) + 1 + k) % N_PORTS;
      if (!found && req[idx])
      begin
        found = 1'b1;
        pick  = port_idx_t'(idx);
      end
    end
  endtask

  task automatic check_outputs();
    logic [3:0] exp_active;
    port_idx_t  g;
    g          = m_grant;
    exp_active = m_no_port ? 4'b0 : (4'b1 << g);
    check_value("o_active", o_active, exp_active);
    check_value("o_hreadymuxm", o_hreadymuxm, m_slave_sel ? hreadyoutm : 1'b1);
    check_value("o_hwdatam", o_hwdatam, wdata[m_data_port]);
    check_value("o_hselm", o_hselm, m_no_port ? 1'b0 : sel[g]);
    check_value("o_hmastlockm", o_hmastlockm, m_no_port ? 1'b0 : mastlock[g]);
    check_value("o_haddrm", o_haddrm, m_no_port ? '0 : addr[g]);
    check_value("o_htransm", o_htransm, m_no_port ? HTRANS_IDLE : trans[g]);
    check_value("o_hwritem", o_hwritem, m_no_port ? 1'b0 : write[g]);
    check_value("o_hsizem", o_hsizem, m_no_port ? '0 : size[g]);
    check_value("o_hburstm", o_hburstm, m_no_port ? '0 : burst[g]);
    check_value("o_hprotm", o_hprotm, m_no_port ? '0 : prot[g]);
    check_value("o_hmasterm", o_hmasterm, m_no_port ? '0 : master[g]);
  endtask

  // Model advances on accepted phases only
  task automatic update_model();
    logic      sel_m, lock_m, lock_arb, found;
    trans_t    trans_m;
    port_idx_t pick;
    sel_m    = m_no_port ? 1'b0 : sel[m_grant];
    lock_m   = m_no_port ? 1'b0 : mastlock[m_grant];
    trans_m  = m_no_port ? HTRANS_IDLE : trans[m_grant];
    lock_arb = lock_m & (sel_m | m_hsel_lock);
    if (m_slave_sel && !hreadyoutm)
      return;                              // Wait state holds everything
    m_data_port = m_grant;
    if (m_locked || lock_arb)
      m_locked = lock_arb;                 // Owner keeps grant
    else
    begin
      m_locked = 1'b0;
      round_robin(sel & held_tran, found, pick);
      m_no_port = !found;
      if (found)
        m_grant = pick;
    end
    m_slave_sel = sel_m;
    if (sel_m && lock_m && (trans_m == HTRANS_NONSEQ || trans_m == HTRANS_SEQ))
      m_hsel_lock = 1'b1;
    else if (!lock_m)
      m_hsel_lock = 1'b0;
  endtask

  task automatic apply_row(input row_t r);
    sel        = r.sel;
    held_tran  = r.held;
    mastlock   = r.lock;
    hreadyoutm = r.ready;
    for (int p = 0; p < N_PORTS; p++)
    begin
      write[p] = r.write & r.held[p];                  // Ports without a transfer stay idle
      trans[p] = r.held[p] ? r.trans : HTRANS_IDLE;
    end
  endtask

  // ----------------------------------------------------------
  // Stimulus table
  // ----------------------------------------------------------
  task automatic build_table();
    repeat (2) add_row(1, 4'h0, 4'h0, 4'h0, 1'b0, 1'b0, HTRANS_IDLE);     // Unselected slave low
    repeat (2) add_row(2, 4'h8, 4'h8, 4'h0, 1'b1, 1'b1, HTRANS_NONSEQ);   // Port 3 alone
    repeat (2) add_row(2, 4'h0, 4'h0, 4'h0, 1'b1, 1'b0, HTRANS_IDLE);
    repeat (6) add_row(3, 4'hf, 4'hf, 4'h0, 1'b1, 1'b1, HTRANS_NONSEQ);   // Rotation
    add_row(4, 4'h2, 4'h2, 4'h2, 1'b1, 1'b1, HTRANS_NONSEQ);              // Locked start
    repeat (2) add_row(4, 4'hf, 4'hf, 4'h2, 1'b1, 1'b1, HTRANS_SEQ);
    repeat (2) add_row(4, 4'hd, 4'hf, 4'h2, 1'b1, 1'b1, HTRANS_SEQ);      // Port 1 deselects
    repeat (2) add_row(4, 4'hf, 4'hf, 4'h2, 1'b1, 1'b1, HTRANS_SEQ);
    repeat (3) add_row(4, 4'hf, 4'hf, 4'h0, 1'b1, 1'b1, HTRANS_NONSEQ);   // Lock released
    repeat (3) add_row(5, 4'hf, 4'hf, 4'h0, 1'b0, 1'b1, HTRANS_NONSEQ);   // Slave stalls
    repeat (2) add_row(5, 4'hf, 4'hf, 4'h0, 1'b1, 1'b1, HTRANS_NONSEQ);
    add_row(6, 4'h1, 4'h1, 4'h0, 1'b1, 1'b1, HTRANS_NONSEQ);              // Write data owner
    add_row(6, 4'h4, 4'h4, 4'h0, 1'b1, 1'b1, HTRANS_NONSEQ);
    repeat (2) add_row(6, 4'h5, 4'h5, 4'h0, 1'b1, 1'b1, HTRANS_NONSEQ);
    repeat (2) add_row(6, 4'h0, 4'h0, 4'h0, 1'b1, 1'b0, HTRANS_IDLE);
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial
  begin
    int cnt;
    void'($urandom(66501));
    HCLK = 1'b0;
    HRESETn = 1'b0;
    sel = '0;
    held_tran = '0;
    write = '0;
    mastlock = '0;
    hreadyoutm = 1'b1;
    for (int p = 0; p < N_PORTS; p++)
    begin
      addr[p]   = {28'($urandom()), 2'(p), 2'b00};    // Port in low bits keeps them distinct
      wdata[p]  = {30'($urandom()), 2'(p)};
      trans[p]  = HTRANS_IDLE;
      size[p]   = 3'(N_PORTS - 1 - p);
      burst[p]  = 3'(p);
      prot[p]   = 4'h8 | 4'(p);
      master[p] = 4'(p + 4);
    end
    m_grant = port_idx_t'(N_PORTS - 1);
    m_no_port = 1'b1;
    m_locked = 1'b0;
    m_slave_sel = 1'b0;
    m_hsel_lock = 1'b0;
    m_data_port = '0;
    build_table();

    repeat (10) @(posedge HCLK);
    #1 HRESETn = 1'b1;
    cnt = 0;
    while (!(o_hreadymuxm === 1'b1 && o_active === 4'h0) && cnt < 20)
    begin
      @(posedge HCLK);
      #1 cnt++;
    end
    if (cnt >= 20)
    begin
      $display("Reset did not settle within 20 cycles");
      $display("TB FAILED");
      $finish;
    end

    for (int i = 0; i < n_rows; i++)
    begin
      apply_row(tbl[i]);
      #4 check_outputs();                  // Sampled mid-cycle
      @(posedge HCLK);
      update_model();
      if (i == n_rows - 1 || tbl[i + 1].test != tbl[i].test)
      begin
        n_tests++;
        $display("Test %0d done, %0d errors", tbl[i].test, test_errors);
        test_errors = 0;
      end
      #1;
    end

    $display("Tests: %0d, checks: %0d, errors: %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

  // Watchdog
  initial
  begin
    #50us;
    $display("Simulation timed out before the table finished");
    $display("TB FAILED");
    $finish;
  end

endmodule

// ==== ahb_out_stage.f ====
hw/ahb_out_pkg.sv
hw/ahb_addr_if.sv
hw/ahb_out_arbiter.sv
hw/ahb_addr_mux.sv
hw/ahb_data_mux.sv
hw/ahb_ready_lock.sv
hw/ahb_out_stage.sv
verification/tb_ahb_out_stage.sv

// ==== Bender.yml ====
package:
  name: ahb_out_stage

sources:
  - files:
      - hw/ahb_out_pkg.sv
      - hw/ahb_addr_if.sv
      - hw/ahb_out_arbiter.sv
      - hw/ahb_addr_mux.sv
      - hw/ahb_data_mux.sv
      - hw/ahb_ready_lock.sv
      - hw/ahb_out_stage.sv
  - target: simulation
    files:
      - verification/tb_ahb_out_stage.sv
